//--- core_fetch.f
design/core_pkg.sv
design/fetch.sv
design/imem_loader.sv
design/imem_arbiter.sv
design/imem.sv
design/core_fetch.sv
dv/core_fetch_tb.sv

//--- Makefile
# Verilator build and run for the fetch front end

SIM  = obj_dir/Vcore_fetch_tb
SRCS = $(shell cat core_fetch.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): core_fetch.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
	  --top-module core_fetch_tb -f core_fetch.f

# Pass or fail comes from the pass message in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx 'SIMULATION PASSED'

clean:
	rm -rf obj_dir

//--- dv/core_fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_fetch_tb;

  localparam int IMEM_DEPTH = 256;
  localparam int AW         = $clog2(IMEM_DEPTH);

  // Phase lengths in cycles
  localparam int RESET_CYCLES    = 16;
  localparam int LOAD_CYCLES     = IMEM_DEPTH;
  localparam int STREAM_CYCLES   = 600;
  localparam int REDIRECT_ROUNDS = 40;
  localparam int ROUND_CYCLES    = 12;
  localparam int REWRITE_CYCLES  = 600;
  localparam int DRAIN_CYCLES    = 48;

  // Twice the longest run the phases can take
  localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + LOAD_CYCLES + STREAM_CYCLES +
      REDIRECT_ROUNDS * ROUND_CYCLES + REWRITE_CYCLES + DRAIN_CYCLES);

  // Pair aligned byte addresses inside the memory
  localparam logic [31:0] PAIR_MASK = 32'(IMEM_DEPTH * 4 - 8);

  // Bytes past the next decode pair that fetch may still read before a rewrite lands
  localparam int AHEAD_BYTES = 48;

  logic                      clk;
  logic                      reset;
  logic                      fetch_en;
  logic                      stall;
  logic                      redirect_en;
  logic [core_pkg::XLEN-1:0] redirect_pc;
  logic                      flush;
  logic [core_pkg::XLEN-1:0] flush_pc;
  core_pkg::load_t           load;
  core_pkg::fetch_bundle_t   decode;
  logic [15:0]               loaded_count;

  // Reference model state
  logic [core_pkg::XLEN-1:0] model [IMEM_DEPTH];
  logic [core_pkg::XLEN-1:0] key;
  logic [core_pkg::XLEN-1:0] exp_instr0;
  logic [core_pkg::XLEN-1:0] exp_instr1;
  logic [core_pkg::XLEN-1:0] exp_pc;
  logic                      load_d1;
  logic [15:0]               exp_count;

  int     strobes;
  int     value_errs;
  int     other_errs;
  int     cycles = 0;
  integer seed;

  core_fetch #(
    .IMEM_DEPTH (IMEM_DEPTH)
  ) i_core_fetch (
    .clk          (clk),
    .reset        (reset),
    .fetch_en     (fetch_en),
    .stall        (stall),
    .redirect_en  (redirect_en),
    .redirect_pc  (redirect_pc),
    .flush        (flush),
    .flush_pc     (flush_pc),
    .load         (load),
    .decode       (decode),
    .loaded_count (loaded_count)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  // ====================================================================
  // Helpers
  // ====================================================================

  function automatic int rand_pct();
    return int'($unsigned($random(seed)) % 100);
  endfunction

  // Loaded word is its byte address XOR the run key
  function automatic logic [31:0] word_value(input logic [AW-1:0] idx);
    return (32'(idx) << 2) ^ key;
  endfunction

  function automatic logic [31:0] random_pair_addr();
    return $unsigned($random(seed)) & PAIR_MASK;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    value_errs++;
    $display("** Error [%s] at %0t: expected %h, actual %h", name, $time, expected, actual);
  endtask

  // Drives one strobe after a falling edge
  // Model follows every strobe
  task automatic send_word(input logic [AW-1:0] idx);
    load.valid = 1'b1;
    load.addr  = 32'(idx) << 2;
    load.data  = word_value(idx);
    model[idx] = word_value(idx);
    strobes++;
  endtask

  // One fetch cycle with random stall and random rewrite strobe
  task automatic drive_cycle(input int stall_pct, input int load_pct);
    logic [AW-1:0] idx;
    logic [31:0]   offset;
    @(negedge clk);
    stall       = rand_pct() < stall_pct;
    redirect_en = 1'b0;
    flush       = 1'b0;
    load        = '0;
    if (rand_pct() < load_pct) begin
      // Rewrite only words that fetch reaches after the write lands
      offset = $unsigned($random(seed)) % (IMEM_DEPTH * 4 - AHEAD_BYTES);
      idx    = AW'((exp_pc + AHEAD_BYTES + offset) >> 2);
      send_word(idx);
    end
  endtask

  // Short run, then a redirect, a flush, or both in one cycle
  task automatic redirect_round(input int round);
    int run_len;
    run_len = 2 + rand_pct() % 8;
    repeat (run_len) drive_cycle(15, 0);
    @(negedge clk);
    stall       = rand_pct() < 30;
    load        = '0;
    redirect_pc = random_pair_addr();
    flush_pc    = random_pair_addr();
    redirect_en = (round % 4) != 1;
    flush       = (round % 4) == 1 || (round % 4) == 3;
  endtask

  task automatic finish_run();
    $display("Summary: %0d value mismatches, %0d other failures, %0d strobes, %0d cycles",
             value_errs, other_errs, strobes, cycles);
    if (value_errs == 0 && other_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  // ====================================================================
  // Reference model of PC order and load count
  // ====================================================================

  assign exp_instr0 = model[decode.pc[0][AW+1:2]];
  assign exp_instr1 = model[decode.pc[1][AW+1:2]];

  // Flush beats redirect
  // A pair counts once decode takes it without stall
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      exp_pc <= '0;
    end else if (flush) begin
      exp_pc <= flush_pc;
    end else if (redirect_en) begin
      exp_pc <= redirect_pc;
    end else if (decode.valid[0] && !stall) begin
      exp_pc <= exp_pc + 8;
    end
  end

  // Strobe registers for one cycle
  // Count moves when the word is written
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      load_d1   <= 1'b0;
      exp_count <= '0;
    end else begin
      load_d1 <= load.valid;
      if (load_d1 && exp_count != 16'hffff) begin
        exp_count <= exp_count + 16'd1;
      end
    end
  end

  // ====================================================================
  // Checks
  // ====================================================================

  a_content0: assert property (@(posedge clk) disable iff (reset)
    decode.valid[0] |-> decode.instr[0] == exp_instr0
  ) else report_mismatch("content_slot0", $sampled(exp_instr0), $sampled(decode.instr[0]));

  a_content1: assert property (@(posedge clk) disable iff (reset)
    decode.valid[1] |-> decode.instr[1] == exp_instr1
  ) else report_mismatch("content_slot1", $sampled(exp_instr1), $sampled(decode.instr[1]));

  a_pc_pair: assert property (@(posedge clk) disable iff (reset)
    decode.valid[1] |-> decode.pc[1] == exp_pc + 4
  ) else report_mismatch("pc_pair", $sampled(exp_pc) + 4, $sampled(decode.pc[1]));

  // Covers plain sequence, stall rewind, redirect target and flush priority
  a_pc_sequence: assert property (@(posedge clk) disable iff (reset)
    decode.valid[0] |-> decode.pc[0] == exp_pc
  ) else report_mismatch("pc_sequence", $sampled(exp_pc), $sampled(decode.pc[0]));

  a_kill: assert property (@(posedge clk) disable iff (reset)
    (flush || redirect_en) |=> decode.valid == '0
  ) else report_mismatch("kill_on_redirect", 32'd0, 32'($sampled(decode.valid)));

  a_loaded_count: assert property (@(posedge clk) disable iff (reset)
    loaded_count == exp_count
  ) else report_mismatch("loaded_count", 32'($sampled(exp_count)),
                         32'($sampled(loaded_count)));

  // Actual shows decode valid bits above the count
  a_reset_state: assert property (@(posedge clk)
    (reset || $past(reset)) |-> (decode.valid == '0 && loaded_count == '0)
  ) else report_mismatch("reset_state", 32'd0,
                         32'({$sampled(decode.valid), $sampled(loaded_count)}));

  // ====================================================================
  // Stimulus
  // ====================================================================

  initial begin
    seed        = 32'he55d1615;
    key         = $random(seed);
    clk         = 1'b0;
    reset       = 1'b1;
    fetch_en    = 1'b0;
    stall       = 1'b0;
    redirect_en = 1'b0;
    redirect_pc = '0;
    flush       = 1'b0;
    flush_pc    = '0;
    load        = '0;
    strobes     = 0;
    value_errs  = 0;
    other_errs  = 0;

    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;

    // Fill the whole memory before any read
    for (int i = 0; i < LOAD_CYCLES; i++) begin
      @(negedge clk);
      send_word(AW'(i));
    end
    @(negedge clk);
    load     = '0;
    fetch_en = 1'b1;

    // Straight stream with random stalls
    repeat (STREAM_CYCLES) drive_cycle(20, 0);

    for (int r = 0; r < REDIRECT_ROUNDS; r++) begin
      redirect_round(r);
    end

    // Loader steals the port while fetch runs
    // New key makes every rewritten word differ from the first fill
    key = $random(seed);
    repeat (REWRITE_CYCLES) drive_cycle(10, 25);
    repeat (DRAIN_CYCLES) drive_cycle(0, 0);

    a_final_count: assert (loaded_count == 16'(strobes)) else begin
      report_mismatch("loaded_count_final", 32'(strobes), 32'(loaded_count));
    end

    finish_run();
  end

  // Watchdog on the cycle counter
  initial begin
    while (cycles < TIMEOUT_CYCLES) @(posedge clk);
    other_errs++;
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    finish_run();
  end

endmodule

`default_nettype wire

//--- design/core_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module core_fetch #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      fetch_en,
  input  logic                      stall,
  input  logic                      redirect_en,
  input  logic [core_pkg::XLEN-1:0] redirect_pc,
  input  logic                      flush,
  input  logic [core_pkg::XLEN-1:0] flush_pc,
  input  core_pkg::load_t           load,
  output core_pkg::fetch_bundle_t   decode,
  output logic [15:0]               loaded_count
);

  // ====================================================================
  // Internal buses
  // ====================================================================

  core_pkg::imem_req_t load_req;
  core_pkg::imem_req_t fetch_req;
  core_pkg::imem_req_t mem_req;
  core_pkg::imem_rsp_t rsp;
  logic                fetch_gnt;

  // PC owner, talks to decode and the arbiter
  fetch i_fetch (
    .clk         (clk),
    .reset       (reset),
    .fetch_en    (fetch_en),
    .stall       (stall),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc),
    .flush       (flush),
    .flush_pc    (flush_pc),
    .fetch_gnt   (fetch_gnt),
    .rsp         (rsp),
    .fetch_req   (fetch_req),
    .decode      (decode)
  );

  // Program loader, write side of the memory
  imem_loader #(
    .IMEM_DEPTH (IMEM_DEPTH)
  ) i_imem_loader (
    .clk          (clk),
    .reset        (reset),
    .load         (load),
    .load_req     (load_req),
    .loaded_count (loaded_count)
  );

  imem_arbiter i_imem_arbiter (
    .clk       (clk),
    .reset     (reset),
    .load_req  (load_req),
    .fetch_req (fetch_req),
    .mem_req   (mem_req),
    .fetch_gnt (fetch_gnt)
  );

  imem #(
    .IMEM_DEPTH (IMEM_DEPTH)
  ) i_imem (
    .clk     (clk),
    .reset   (reset),
    .mem_req (mem_req),
    .rsp     (rsp)
  );

endmodule

`default_nettype wire

//--- design/imem.sv
`timescale 1ns/1ps
`default_nettype none

module imem #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic                clk,
  input  logic                reset,
  input  core_pkg::imem_req_t mem_req,
  output core_pkg::imem_rsp_t rsp
);

  // Word index width
  localparam int AW = $clog2(IMEM_DEPTH);

  logic [core_pkg::XLEN-1:0] mem [IMEM_DEPTH];

  logic [AW-1:0] idx0;
  logic [AW-1:0] idx1;
  logic          rd_en;
  logic          wr_en;

  logic                                                 rsp_valid_q;
  logic [core_pkg::FETCH_WIDTH-1:0][core_pkg::XLEN-1:0] rsp_pc_q;
  logic [core_pkg::FETCH_WIDTH-1:0][core_pkg::XLEN-1:0] rsp_rdata_q;

  // ====================================================================
  // Port decode
  // ====================================================================

  assign rd_en = mem_req.valid && !mem_req.write;
  assign wr_en = mem_req.valid && mem_req.write;

  // Byte address to word index
  // Second word wraps at the top
  assign idx0 = mem_req.addr[AW+1:2];
  assign idx1 = idx0 + 1'b1;

  // ====================================================================
  // Storage
  // ====================================================================

  // Word storage filled by the loader
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[idx0] <= mem_req.wdata;
    end
  end

  // ====================================================================
  // Registered read response
  // ====================================================================

  // One pulse per read
  // Writes get no answer
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rsp_pc_q[0]    <= mem_req.addr;
      rsp_pc_q[1]    <= mem_req.addr + 4;
      rsp_rdata_q[0] <= mem[idx0];
      rsp_rdata_q[1] <= mem[idx1];
    end
  end

  always_comb begin
    rsp.valid = rsp_valid_q;
    rsp.pc    = rsp_pc_q;
    rsp.rdata = rsp_rdata_q;
  end

endmodule

`default_nettype wire

//--- design/imem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module imem_arbiter (
  input  logic                clk,
  input  logic                reset,
  input  core_pkg::imem_req_t load_req,
  input  core_pkg::imem_req_t fetch_req,
  output core_pkg::imem_req_t mem_req,
  output logic                fetch_gnt
);

  // Longest run of refused fetch cycles the loader may cause
  localparam int MAX_REFUSE = 64;

  logic [6:0] refuse_cnt;

  // ====================================================================
  // Fixed priority, loader first
  // ====================================================================

  // Loader has no back-pressure and always wins
  always_comb begin
    if (load_req.valid) begin
      mem_req = load_req;
    end else if (fetch_req.valid) begin
      mem_req = fetch_req;
    end else begin
      // Idle port
      mem_req = '0;
    end
  end

  // Grant only when the fetch read is the one on the port
  assign fetch_gnt = fetch_req.valid && !load_req.valid;

  // ====================================================================
  // Starvation tracking
  // ====================================================================

  // Consecutive cycles fetch asked and lost
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      refuse_cnt <= '0;
    end else if (fetch_req.valid && !fetch_gnt) begin
      if (refuse_cnt != '1) begin
        refuse_cnt <= refuse_cnt + 7'd1;
      end
    end else begin
      refuse_cnt <= '0;
    end
  end

  a_no_fetch_starvation: assert property (
    @(posedge clk) disable iff (reset) refuse_cnt <= 7'(MAX_REFUSE)
  ) else $error("imem_arbiter: fetch refused for %0d cycles", refuse_cnt);

endmodule

`default_nettype wire

//--- design/imem_loader.sv
`timescale 1ns/1ps
`default_nettype none

module imem_loader #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic                clk,
  input  logic                reset,
  input  core_pkg::load_t     load,
  output core_pkg::imem_req_t load_req,
  output logic [15:0]         loaded_count
);

  // Byte address bits that fall inside the memory
  localparam int BYTE_AW = $clog2(IMEM_DEPTH) + 2;

  logic        req_valid_q;
  logic [BYTE_AW-1:0] req_addr_q;
  logic [core_pkg::XLEN-1:0] req_data_q;
  logic [15:0] count_q;

  // ====================================================================
  // Strobe to write request
  // ====================================================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= load.valid;
    end
  end

  // Address wraps to the memory size
  always_ff @(posedge clk) begin
    if (load.valid) begin
      req_addr_q <= load.addr[BYTE_AW-1:0];
      req_data_q <= load.data;
    end
  end

  always_comb begin
    load_req.valid = req_valid_q;
    load_req.write = 1'b1;
    load_req.addr  = {{(core_pkg::XLEN-BYTE_AW){1'b0}}, req_addr_q};
    load_req.wdata = req_data_q;
  end

  // ====================================================================
  // Loaded word count
  // ====================================================================

  // Counts at the edge the word is written, sticks at all ones
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count_q <= '0;
    end else if (req_valid_q && count_q != 16'hffff) begin
      count_q <= count_q + 16'd1;
    end
  end

  assign loaded_count = count_q;

  // Memory is word addressed, low bits would be silently lost
  a_load_word_aligned: assert property (
    @(posedge clk) disable iff (reset) load.valid |-> load.addr[1:0] == 2'b00
  ) else $error("imem_loader: unaligned load address %h", load.addr);

endmodule

`default_nettype wire

//--- design/fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fetch (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      fetch_en,
  input  logic                      stall,
  input  logic                      redirect_en,
  input  logic [core_pkg::XLEN-1:0] redirect_pc,
  input  logic                      flush,
  input  logic [core_pkg::XLEN-1:0] flush_pc,
  input  logic                      fetch_gnt,
  input  core_pkg::imem_rsp_t       rsp,
  output core_pkg::imem_req_t       fetch_req,
  output core_pkg::fetch_bundle_t   decode
);

  // Byte distance between two consecutive pairs
  localparam logic [core_pkg::XLEN-1:0] PAIR_STEP = 8;

  logic [core_pkg::XLEN-1:0] pc_q;
  logic [core_pkg::XLEN-1:0] pc_next;
  logic                      rewind;

  // Decode stage registers
  logic [core_pkg::FETCH_WIDTH-1:0]                     dec_valid;
  logic [core_pkg::FETCH_WIDTH-1:0][core_pkg::XLEN-1:0] dec_pc;
  logic [core_pkg::FETCH_WIDTH-1:0][core_pkg::XLEN-1:0] dec_instr;

  // ====================================================================
  // PC register and next-PC priority
  // ====================================================================

  // A response landing during stall is dropped, so fetch must go back to it
  assign rewind = stall && rsp.valid;

  always_comb begin
    if (flush) begin
      // Commit flush beats everything
      pc_next = flush_pc;
    end else if (redirect_en) begin
      // Branch resolution
      pc_next = redirect_pc;
    end else if (rewind) begin
      // Refetch the pair that decode could not take
      pc_next = rsp.pc[0];
    end else if (fetch_req.valid && fetch_gnt) begin
      pc_next = pc_q + PAIR_STEP;
    end else begin
      // Not granted, loader holds the port
      pc_next = pc_q;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_next;
    end
  end

  // ====================================================================
  // Memory request
  // ====================================================================

  always_comb begin
    fetch_req.valid = fetch_en && !stall && !redirect_en && !flush;
    fetch_req.write = 1'b0;
    fetch_req.addr  = pc_q;
    // Reads carry no data
    fetch_req.wdata = '0;
  end

  // ====================================================================
  // Registered decode output
  // ====================================================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dec_valid <= '0;
    end else if (flush || redirect_en) begin
      // Wrong-path pair, including the one in flight
      dec_valid <= '0;
    end else if (!stall) begin
      // One valid cycle per accepted response
      dec_valid <= {core_pkg::FETCH_WIDTH{rsp.valid}};
    end
  end

  // Payload only, qualified by dec_valid
  always_ff @(posedge clk) begin
    if (!stall && rsp.valid) begin
      dec_pc    <= rsp.pc;
      dec_instr <= rsp.rdata;
    end
  end

  always_comb begin
    decode.valid = dec_valid;
    decode.pc    = dec_pc;
    decode.instr = dec_instr;
  end

  // ====================================================================
  // Assertions
  // ====================================================================

  // Flush, redirect and rewind targets all keep pair alignment
  a_pc_pair_aligned: assert property (
    @(posedge clk) disable iff (reset) pc_q[2:0] == 3'b000
  ) else $error("fetch: PC not pair aligned, pc=%h", pc_q);

  // Memory pairs the two words, decode must see consecutive PCs
  a_decode_pc_pair: assert property (
    @(posedge clk) disable iff (reset)
    dec_valid[0] |-> dec_pc[1] == dec_pc[0] + 4
  ) else $error("fetch: decode pc pair broken, pc0=%h pc1=%h", dec_pc[0], dec_pc[1]);

endmodule

`default_nettype wire

//--- design/core_pkg.sv
`default_nettype none

package core_pkg;

  // ====================================================================
  // Widths
  // ====================================================================

  // Address and instruction width
  localparam int XLEN = 32;

  // Instructions per fetch pair, the pair datapath is fixed at two
  localparam int FETCH_WIDTH = 2;

  // ====================================================================
  // Memory port
  // ====================================================================

  // One request on the single memory port
  // For a read, addr is the pair base and both addr and addr+4 come back
  typedef struct packed {
    logic            valid;
    logic            write;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } imem_req_t;

  // Registered read response, one cycle after a granted read
  typedef struct packed {
    logic                             valid;
    logic [FETCH_WIDTH-1:0][XLEN-1:0] pc;
    logic [FETCH_WIDTH-1:0][XLEN-1:0] rdata;
  } imem_rsp_t;

  // ====================================================================
  // Decode side and loader side
  // ====================================================================

  // Aligned instruction pair handed to decode
  typedef struct packed {
    logic [FETCH_WIDTH-1:0]           valid;
    logic [FETCH_WIDTH-1:0][XLEN-1:0] pc;
    logic [FETCH_WIDTH-1:0][XLEN-1:0] instr;
  } fetch_bundle_t;

  // External load strobe, single cycle, never refused
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] data;
  } load_t;

endpackage

`default_nettype wire
